//--- Makefile
# Verilator build and run of the multicycle core testbench
VERILATOR ?= verilator
TOP       ?= cpuTb
MDIR      ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(MDIR)

# the run fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(MDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(MDIR)

//--- build.f
+incdir+include
source/cpuPkg.sv
source/alu.sv
source/regFile.sv
source/wordMemory.sv
source/controlUnit.sv
source/datapath.sv
source/cpuTop.sv
tb/cpuTop_props.sv
tb/cpuTb.sv

//--- include/cpu_cfg.svh
// build-time sizes for the RV64 multicycle core
// data width, register count and memory depths
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// data and address width
`define XLEN       64
`define REG_COUNT  32
// instruction memory in 32-bit words
`define IMEM_WORDS 64
// data memory in 64-bit words
`define DMEM_WORDS 32

`endif

//--- source/alu.sv
// arithmetic and logic unit
// add, sub, and, or, xor and pass-through of b
// zero flag on an all-zero result
`timescale 1ns/1ps

module alu (
    input  cpuPkg::word_t  a,
    input  cpuPkg::word_t  b,
    input  cpuPkg::aluOp_t op,
    output cpuPkg::word_t  result,
    output logic           zero
);
    import cpuPkg::*;

    always_comb begin
        case (op)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluAnd:   result = a & b;
            aluOr:    result = a | b;
            aluXor:   result = a ^ b;
            aluPassB: result = b;
            default:  result = a + b;
        endcase
    end

    // beq relies on this after a subtract
    assign zero = (result == '0);
endmodule

//--- source/controlUnit.sv
// control unit of the multicycle core
// FSM over the instruction phases, decodes the
// instruction register and drives the control flags
`timescale 1ns/1ps

module controlUnit (
    input  logic               clk,
    input  logic               rstN,
    input  cpuPkg::instr_t     instr,
    input  logic               zero,
    output cpuPkg::ctrlFlags_t ctrl
);
    import cpuPkg::*;

    cpuState_t  state;
    cpuState_t  nextState;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    aluOp_t     fieldOp;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    // ALU operation of R and I instructions
    always_comb begin
        case (funct3)
            3'b000:  fieldOp = (opcode == opReg && funct7b5) ? aluSub : aluAdd;
            3'b100:  fieldOp = aluXor;
            3'b110:  fieldOp = aluOr;
            3'b111:  fieldOp = aluAnd;
            default: fieldOp = aluAdd;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= stFetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        // everything off unless the state asks for it
        ctrl      = '0;
        nextState = stFetch;
        case (state)
            stFetch: begin
                ctrl.irWrite  = 1'b1;
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSource = pcAluResult;
                ctrl.aluSrcA  = srcAPc;
                ctrl.aluSrcB  = srcBFour;
                ctrl.aluOp    = aluAdd;
                nextState     = stDecode;
            end
            stDecode: begin
                // branch target goes into the ALU output register
                ctrl.loadRegA   = 1'b1;
                ctrl.loadRegB   = 1'b1;
                ctrl.loadAluOut = 1'b1;
                ctrl.aluSrcA    = srcAPc;
                ctrl.aluSrcB    = srcBBranchImm;
                ctrl.aluOp      = aluAdd;
                case (opcode)
                    opLoad:   nextState = stMemAddr;
                    opStore:  nextState = stMemAddr;
                    opImm:    nextState = stExecI;
                    opReg:    nextState = stExecR;
                    opLui:    nextState = stExecU;
                    opBranch: nextState = stBranch;
                    default:  nextState = stFetch;
                endcase
            end
            stMemAddr: begin
                ctrl.loadAluOut = 1'b1;
                ctrl.aluSrcA    = srcARegA;
                ctrl.aluSrcB    = srcBImm;
                ctrl.aluOp      = aluAdd;
                case (opcode)
                    opStore: nextState = stMemStore;
                    default: nextState = stMemLoad;
                endcase
            end
            stExecR: begin
                ctrl.loadAluOut = 1'b1;
                ctrl.aluSrcA    = srcARegA;
                ctrl.aluSrcB    = srcBRegB;
                ctrl.aluOp      = fieldOp;
                nextState       = stAluComplete;
            end
            stExecI: begin
                ctrl.loadAluOut = 1'b1;
                ctrl.aluSrcA    = srcARegA;
                ctrl.aluSrcB    = srcBImm;
                ctrl.aluOp      = fieldOp;
                nextState       = stAluComplete;
            end
            stExecU: begin
                ctrl.loadAluOut = 1'b1;
                ctrl.aluSrcB    = srcBImm;
                ctrl.aluOp      = aluPassB;
                nextState       = stAluComplete;
            end
            stBranch: begin
                // datapath takes the target only on a zero compare
                ctrl.pcWriteCond = 1'b1;
                ctrl.pcSource    = pcAluOut;
                ctrl.aluSrcA     = srcARegA;
                ctrl.aluSrcB     = srcBRegB;
                ctrl.aluOp       = aluSub;
                nextState        = stFetch;
            end
            stMemLoad: begin
                ctrl.loadMdr = 1'b1;
                nextState    = stWriteBack;
            end
            stMemStore: begin
                ctrl.dMemWrite = 1'b1;
                nextState      = stFetch;
            end
            stWriteBack: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                nextState     = stFetch;
            end
            stAluComplete: begin
                ctrl.regWrite = 1'b1;
                nextState     = stFetch;
            end
            default: begin
                nextState = stFetch;
            end
        endcase
    end
endmodule

//--- source/cpuPkg.sv
// shared types for the multicycle core
// vector types, control flag bundle and FSM states
// opcode, ALU operation and source select constants
`include "cpu_cfg.svh"

package cpuPkg;
    typedef logic [`XLEN-1:0] word_t;
    typedef logic [31:0]      instr_t;
    typedef logic [4:0]       regAddr_t;
    typedef logic [2:0]       aluOp_t;

    localparam aluOp_t aluAdd   = 3'd0;
    localparam aluOp_t aluSub   = 3'd1;
    localparam aluOp_t aluAnd   = 3'd2;
    localparam aluOp_t aluOr    = 3'd3;
    localparam aluOp_t aluXor   = 3'd4;
    localparam aluOp_t aluPassB = 3'd5;

    // operand and PC source selects
    localparam logic       srcAPc        = 1'b0;
    localparam logic       srcARegA      = 1'b1;
    localparam logic [1:0] srcBRegB      = 2'd0;
    localparam logic [1:0] srcBFour      = 2'd1;
    localparam logic [1:0] srcBImm       = 2'd2;
    localparam logic [1:0] srcBBranchImm = 2'd3;
    localparam logic       pcAluResult   = 1'b0;
    localparam logic       pcAluOut      = 1'b1;

    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opBranch = 7'b1100011;

    typedef struct packed {
        logic       pcWrite;
        logic       pcWriteCond;
        logic       pcSource;
        logic       aluSrcA;
        logic [1:0] aluSrcB;
        aluOp_t     aluOp;
        logic       loadAluOut;
        logic       regWrite;
        logic       loadRegA;
        logic       loadRegB;
        logic       memToReg;
        logic       dMemWrite;
        logic       loadMdr;
        logic       irWrite;
    } ctrlFlags_t;

    typedef enum logic [3:0] {
        stFetch,
        stDecode,
        stMemAddr,
        stExecR,
        stExecI,
        stExecU,
        stBranch,
        stMemLoad,
        stMemStore,
        stWriteBack,
        stAluComplete
    } cpuState_t;
endpackage

//--- source/cpuTop.sv
// top level of the multicycle core
// control unit, datapath, instruction and data memory
// program load port and write observation ports
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpuTop (
    input  logic             clk,
    input  logic             rstN,
    input  logic             progWe,
    input  cpuPkg::word_t    progAddr,
    input  cpuPkg::instr_t   progData,
    output logic             regWe,
    output cpuPkg::regAddr_t regAddr,
    output cpuPkg::word_t    regData,
    output logic             storeWe,
    output cpuPkg::word_t    storeAddr,
    output cpuPkg::word_t    storeData
);
    import cpuPkg::*;

    ctrlFlags_t ctrl;
    instr_t     instr;
    instr_t     iMemData;
    logic       zero;
    word_t      pc;
    word_t      iMemAddr;
    word_t      dMemData;

    controlUnit control (
        .clk   (clk),
        .rstN  (rstN),
        .instr (instr),
        .zero  (zero),
        .ctrl  (ctrl)
    );

    datapath dp (
        .clk       (clk),
        .rstN      (rstN),
        .ctrl      (ctrl),
        .iMemData  (iMemData),
        .dMemData  (dMemData),
        .instr     (instr),
        .zero      (zero),
        .pc        (pc),
        .dMemAddr  (storeAddr),
        .dMemWData (storeData),
        .dMemWe    (storeWe),
        .regWe     (regWe),
        .regAddr   (regAddr),
        .regData   (regData)
    );

    // load port takes the address while a program is written
    assign iMemAddr = progWe ? progAddr : pc;

    wordMemory #(
        .dataWidth ($bits(instr_t)),
        .depth     (`IMEM_WORDS)
    ) iMem (
        .clk   (clk),
        .we    (progWe),
        .addr  (iMemAddr),
        .wData (progData),
        .rData (iMemData)
    );

    wordMemory #(
        .dataWidth (`XLEN),
        .depth     (`DMEM_WORDS)
    ) dMem (
        .clk   (clk),
        .we    (storeWe),
        .addr  (storeAddr),
        .wData (storeData),
        .rData (dMemData)
    );
endmodule

//--- source/datapath.sv
// datapath of the multicycle core
// PC, instruction register, operand, ALU output and
// memory data registers, immediates and source muxes
`timescale 1ns/1ps

module datapath (
    input  logic               clk,
    input  logic               rstN,
    input  cpuPkg::ctrlFlags_t ctrl,
    input  cpuPkg::instr_t     iMemData,
    input  cpuPkg::word_t      dMemData,
    output cpuPkg::instr_t     instr,
    output logic               zero,
    output cpuPkg::word_t      pc,
    output cpuPkg::word_t      dMemAddr,
    output cpuPkg::word_t      dMemWData,
    output logic               dMemWe,
    output logic               regWe,
    output cpuPkg::regAddr_t   regAddr,
    output cpuPkg::word_t      regData
);
    import cpuPkg::*;

    localparam int xlen = $bits(word_t);

    word_t regA;
    word_t regB;
    word_t aluOut;
    word_t mdr;
    word_t rDataA;
    word_t rDataB;
    word_t aluA;
    word_t aluB;
    word_t aluResult;
    word_t immI;
    word_t immS;
    word_t immB;
    word_t immU;
    word_t immSel;
    word_t branchOffset;
    word_t wbData;

    assign immI = {{(xlen - 12){instr[31]}}, instr[31:20]};
    assign immS = {{(xlen - 12){instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{(xlen - 13){instr[31]}}, instr[31], instr[7], instr[30:25],
                   instr[11:8], 1'b0};
    assign immU = {{(xlen - 32){instr[31]}}, instr[31:12], 12'b0};

    // PC has already moved past the branch in decode
    assign branchOffset = immB - word_t'(4);

    always_comb begin
        case (instr[6:0])
            opStore: immSel = immS;
            opLui:   immSel = immU;
            default: immSel = immI;
        endcase
    end

    assign aluA = (ctrl.aluSrcA == srcARegA) ? regA : pc;

    always_comb begin
        case (ctrl.aluSrcB)
            srcBRegB: aluB = regB;
            srcBFour: aluB = word_t'(4);
            srcBImm:  aluB = immSel;
            default:  aluB = branchOffset;
        endcase
    end

    alu aluInst (
        .a      (aluA),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (zero)
    );

    assign wbData = ctrl.memToReg ? mdr : aluOut;

    regFile regs (
        .clk    (clk),
        .rstN   (rstN),
        .rAddrA (instr[19:15]),
        .rAddrB (instr[24:20]),
        .wAddr  (instr[11:7]),
        .we     (ctrl.regWrite),
        .wData  (wbData),
        .rDataA (rDataA),
        .rDataB (rDataB)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc    <= '0;
            instr <= '0;
        end else begin
            if (ctrl.pcWrite || (ctrl.pcWriteCond && zero)) begin
                pc <= (ctrl.pcSource == pcAluOut) ? aluOut : aluResult;
            end
            if (ctrl.irWrite) begin
                instr <= iMemData;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.loadRegA) begin
            regA <= rDataA;
        end
        if (ctrl.loadRegB) begin
            regB <= rDataB;
        end
        if (ctrl.loadAluOut) begin
            aluOut <= aluResult;
        end
        if (ctrl.loadMdr) begin
            mdr <= dMemData;
        end
    end

    assign dMemAddr  = aluOut;
    assign dMemWData = regB;
    assign dMemWe    = ctrl.dMemWrite;
    assign regWe     = ctrl.regWrite;
    assign regAddr   = instr[11:7];
    assign regData   = wbData;
endmodule

//--- source/regFile.sv
// integer register file
// two combinational read ports, one clocked write port
// x0 always reads zero
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module regFile (
    input  logic             clk,
    input  logic             rstN,
    input  cpuPkg::regAddr_t rAddrA,
    input  cpuPkg::regAddr_t rAddrB,
    input  cpuPkg::regAddr_t wAddr,
    input  logic             we,
    input  cpuPkg::word_t    wData,
    output cpuPkg::word_t    rDataA,
    output cpuPkg::word_t    rDataB
);
    import cpuPkg::*;

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wAddr != '0) begin
            regs[wAddr] <= wData;
        end
    end

    assign rDataA = regs[rAddrA];
    assign rDataB = regs[rAddrB];
endmodule

//--- source/wordMemory.sv
// word-addressed memory
// byte address in, low bits dropped to index words
// combinational read, clocked write
`timescale 1ns/1ps

module wordMemory #(
    parameter int dataWidth = 32,
    parameter int depth     = 64
) (
    input  logic                 clk,
    input  logic                 we,
    input  cpuPkg::word_t        addr,
    input  logic [dataWidth-1:0] wData,
    output logic [dataWidth-1:0] rData
);
    localparam int offsetBits = $clog2(dataWidth / 8);
    localparam int indexBits  = $clog2(depth);

    logic [dataWidth-1:0] mem [depth];
    logic [indexBits-1:0] index;

    // upper bits wrap around the array
    assign index = addr[offsetBits +: indexBits];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wData;
        end
    end

    assign rData = mem[index];
endmodule

//--- tb/cpuTb.sv
// testbench for the multicycle core
// clock, reset and program loading over the load port
// program table with expected write events, built from ISA rules
// LFSR immediates, event checks, watchdog and closing result line
`timescale 1ns/1ps

module cpuTb;
    import cpuPkg::*;

    localparam int periodNs    = 20;
    localparam int resetCycles = 3;
    localparam int xBits       = $bits(word_t);

    localparam logic [1:0] evNone  = 2'd0;
    localparam logic [1:0] evReg   = 2'd1;
    localparam logic [1:0] evStore = 2'd2;

    // one program word and the write it should cause
    typedef struct packed {
        instr_t     instr;
        logic [1:0] kind;
        word_t      addr;
        word_t      value;
        logic [7:0] cycles;
    } row_t;

    logic     clk;
    logic     rstN;
    logic     progWe;
    word_t    progAddr;
    instr_t   progData;
    logic     regWe;
    regAddr_t regAddr;
    word_t    regData;
    logic     storeWe;
    word_t    storeAddr;
    word_t    storeData;

    row_t        rows [$];
    word_t       refRegs [32];
    word_t       refMem [word_t];
    logic [31:0] lfsr       = 32'h86592f62;
    logic        tableReady = 1'b0;
    int          checks     = 0;
    int          errors     = 0;

    cpuTop i_cpuTop (
        .clk       (clk),
        .rstN      (rstN),
        .progWe    (progWe),
        .progAddr  (progAddr),
        .progData  (progData),
        .regWe     (regWe),
        .regAddr   (regAddr),
        .regData   (regData),
        .storeWe   (storeWe),
        .storeAddr (storeAddr),
        .storeData (storeData)
    );

    bind cpuTop cpuTop_props props (
        .clk     (clk),
        .rstN    (rstN),
        .regWe   (regWe),
        .storeWe (storeWe),
        .regAddr (regAddr)
    );

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t sext12(input logic [11:0] imm);
        return {{(xBits - 12){imm[11]}}, imm};
    endfunction

    // RV64 instruction formats
    function automatic instr_t encI(input logic [6:0] op, input regAddr_t rd,
                                    input logic [2:0] f3, input regAddr_t rs1,
                                    input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instr_t encR(input logic [6:0] f7, input regAddr_t rs2,
                                    input regAddr_t rs1, input logic [2:0] f3,
                                    input regAddr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic instr_t encS(input regAddr_t rs2, input regAddr_t rs1,
                                    input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
    endfunction

    function automatic instr_t encB(input regAddr_t rs1, input regAddr_t rs2,
                                    input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic drawImm(output logic [11:0] imm);
        imm = '0;
        for (int b = 0; b < 12; b++) begin
            lfsr = lfsrStep(lfsr);
            imm  = {imm[10:0], lfsr[0]};
        end
    endtask

    task automatic addRow(input instr_t ins, input logic [1:0] kind, input word_t addr,
                          input word_t value, input logic [7:0] cycles);
        row_t r;
        r.instr  = ins;
        r.kind   = kind;
        r.addr   = addr;
        r.value  = value;
        r.cycles = cycles;
        rows.push_back(r);
    endtask

    task automatic aluImm(input logic [2:0] f3, input regAddr_t rd, input regAddr_t rs1,
                          input logic [11:0] imm);
        word_t r;
        case (f3)
            3'b100:  r = refRegs[rs1] ^ sext12(imm);
            3'b110:  r = refRegs[rs1] | sext12(imm);
            3'b111:  r = refRegs[rs1] & sext12(imm);
            default: r = refRegs[rs1] + sext12(imm);
        endcase
        refRegs[rd] = r;
        addRow(encI(7'b0010011, rd, f3, rs1, imm), evReg, word_t'(rd), r, 8'd4);
    endtask

    task automatic randomImmOp(input logic [2:0] f3, input regAddr_t rd,
                               input regAddr_t rs1);
        logic [11:0] imm;
        drawImm(imm);
        aluImm(f3, rd, rs1, imm);
    endtask

    task automatic regOp(input logic [2:0] f3, input logic [6:0] f7, input regAddr_t rd,
                         input regAddr_t rs1, input regAddr_t rs2);
        word_t r;
        case (f3)
            3'b100:  r = refRegs[rs1] ^ refRegs[rs2];
            3'b110:  r = refRegs[rs1] | refRegs[rs2];
            3'b111:  r = refRegs[rs1] & refRegs[rs2];
            default: r = f7[5] ? refRegs[rs1] - refRegs[rs2] : refRegs[rs1] + refRegs[rs2];
        endcase
        refRegs[rd] = r;
        addRow(encR(f7, rs2, rs1, f3, rd), evReg, word_t'(rd), r, 8'd4);
    endtask

    task automatic luiOp(input regAddr_t rd, input logic [19:0] imm);
        word_t r;
        r = {{(xBits - 32){imm[19]}}, imm, 12'b0};
        refRegs[rd] = r;
        addRow({imm, rd, 7'b0110111}, evReg, word_t'(rd), r, 8'd4);
    endtask

    task automatic storeOp(input regAddr_t rs2, input regAddr_t rs1, input logic [11:0] imm);
        word_t a;
        a = refRegs[rs1] + sext12(imm);
        refMem[a] = refRegs[rs2];
        addRow(encS(rs2, rs1, imm), evStore, a, refRegs[rs2], 8'd4);
    endtask

    task automatic loadOp(input regAddr_t rd, input regAddr_t rs1, input logic [11:0] imm);
        word_t a;
        a = refRegs[rs1] + sext12(imm);
        refRegs[rd] = refMem[a];
        addRow(encI(7'b0000011, rd, 3'b011, rs1, imm), evReg, word_t'(rd), refRegs[rd], 8'd5);
    endtask

    task automatic branchOp(input regAddr_t rs1, input regAddr_t rs2, input logic [12:0] off,
                            output logic taken);
        taken = (refRegs[rs1] == refRegs[rs2]);
        addRow(encB(rs1, rs2, off), evNone, '0, '0, 8'd3);
    endtask

    // a skipped instruction costs no cycles and writes nothing
    task automatic guardedAddi(input logic skipped, input regAddr_t rd, input regAddr_t rs1,
                               input logic [11:0] imm);
        if (skipped) begin
            addRow(encI(7'b0010011, rd, 3'b000, rs1, imm), evNone, '0, '0, 8'd0);
        end else begin
            aluImm(3'b000, rd, rs1, imm);
        end
    endtask

    task automatic buildProgram();
        logic taken;
        foreach (refRegs[i]) begin
            refRegs[i] = '0;
        end
        randomImmOp(3'b000, 5'd1, 5'd0);
        randomImmOp(3'b000, 5'd2, 5'd0);
        randomImmOp(3'b111, 5'd3, 5'd1);
        randomImmOp(3'b110, 5'd4, 5'd2);
        randomImmOp(3'b100, 5'd5, 5'd1);
        luiOp(5'd6, 20'h8a5c3);
        regOp(3'b000, 7'b0000000, 5'd7, 5'd1, 5'd2);
        regOp(3'b000, 7'b0100000, 5'd8, 5'd1, 5'd2);
        regOp(3'b111, 7'b0000000, 5'd9, 5'd6, 5'd4);
        regOp(3'b110, 7'b0000000, 5'd10, 5'd3, 5'd5);
        regOp(3'b100, 7'b0000000, 5'd11, 5'd7, 5'd8);
        storeOp(5'd11, 5'd0, 12'd16);
        loadOp(5'd12, 5'd0, 12'd16);
        branchOp(5'd1, 5'd1, 13'd8, taken);
        guardedAddi(taken, 5'd13, 5'd0, 12'd5);
        // x6 has zero low bits and a large upper part, never equal to x1
        branchOp(5'd1, 5'd6, 13'd8, taken);
        guardedAddi(taken, 5'd14, 5'd12, 12'd7);
        // halt by branching onto itself
        branchOp(5'd0, 5'd0, 13'd0, taken);
    endtask

    task automatic compareValue(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    task automatic checkRow(input row_t row, input int expGap);
        int         gap;
        logic [1:0] gotKind;
        gap = 0;
        do begin
            @(negedge clk);
            gap++;
        end while (!(regWe || storeWe));
        gotKind = regWe ? evReg : evStore;
        compareValue("cycles between writes", word_t'(gap), word_t'(expGap));
        compareValue("event kind", word_t'(gotKind), word_t'(row.kind));
        if (gotKind == row.kind && row.kind == evReg) begin
            compareValue("regAddr", word_t'(regAddr), row.addr);
            compareValue("regData", regData, row.value);
        end
        if (gotKind == row.kind && row.kind == evStore) begin
            compareValue("storeAddr", storeAddr, row.addr);
            compareValue("storeData", storeData, row.value);
        end
    endtask

    initial begin
        int pending;
        rstN     <= 1'b0;
        progWe   <= 1'b0;
        progAddr <= '0;
        progData <= '0;
        buildProgram();
        tableReady = 1'b1;

        // program goes in while the core is held in reset
        foreach (rows[i]) begin
            @(posedge clk);
            progWe   <= 1'b1;
            progAddr <= word_t'(4 * i);
            progData <= rows[i].instr;
        end
        @(posedge clk);
        progWe <= 1'b0;
        repeat (resetCycles) begin
            @(negedge clk);
            if (regWe || storeWe) begin
                errors++;
                $display("write strobe high during reset at %0t", $time);
            end
        end
        @(posedge clk);
        rstN <= 1'b1;

        // gaps count from the release edge, beq and skipped rows add up
        pending = 0;
        foreach (rows[i]) begin
            pending = pending + int'(rows[i].cycles);
            if (rows[i].kind != evNone) begin
                checkRow(rows[i], pending);
                pending = 0;
            end
        end
        repeat (pending + 6) begin
            @(negedge clk);
            if (regWe || storeWe) begin
                errors++;
                $display("unexpected write after the last program row at %0t", $time);
            end
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // loading and reset cycles, then 20 cycles per row
    initial begin
        int limit;
        wait (tableReady);
        limit = rows.size() * 20 + rows.size() + 2 + resetCycles;
        #(limit * periodNs);
        $display("watchdog expired after %0d cycles without a result", limit);
        $display("Verification failed");
        $finish;
    end
endmodule

//--- tb/cpuTop_props.sv
// concurrent assertions on the write strobes of the core
// strobe exclusion, single-cycle strobes, no x0 write,
// strobes quiet during reset
`timescale 1ns/1ps

module cpuTop_props (
    input logic             clk,
    input logic             rstN,
    input logic             regWe,
    input logic             storeWe,
    input cpuPkg::regAddr_t regAddr
);
    oneStrobe: assert property (@(posedge clk) disable iff (!rstN)
        !(regWe && storeWe))
        else $error("register write and store strobes high in the same cycle");

    singleCycleWrite: assert property (@(posedge clk) disable iff (!rstN)
        regWe |=> !regWe)
        else $error("register write strobe high for two cycles in a row");

    noZeroWrite: assert property (@(posedge clk) disable iff (!rstN)
        regWe |-> (regAddr != '0))
        else $error("register write aimed at x0");

    // nothing may be written while the core is held
    quietInReset: assert property (@(posedge clk)
        !rstN |-> (!regWe && !storeWe))
        else $error("write strobe high during reset");
endmodule
